//--- include/tracker_defines.svh
`ifndef TRACKER_DEFINES_SVH
`define TRACKER_DEFINES_SVH

// camera frame geometry in pixels
`define FRAME_W 320
`define FRAME_H 240

// pipeline depth in pixel clocks
`define CONV_LATENCY 3 // unpack + rgb to ycrcb
`define MASK_LATENCY 1 // channel select and threshold register

// rgb to ycrcb weights, scaled by 256
// luma gets +128 rounding, >> 8, then +16
`define COEF_Y_R  66
`define COEF_Y_G  129
`define COEF_Y_B  25

// chroma gets +128 rounding, arithmetic >> 8, then +128
`define COEF_CB_R (-38)
`define COEF_CB_G (-74)
`define COEF_CB_B 112

`define COEF_CR_R 112
`define COEF_CR_G (-94)
`define COEF_CR_B (-18)

`endif

//--- hw/tracker_pkg.sv
package tracker_pkg;

  // raw camera word, r[15:11] g[10:5] b[4:0]
  typedef logic [15:0] pixel565_t;

  // any 8 bit color plane (r, g, b, y, cr, cb)
  typedef logic [7:0] color8_t;

  typedef logic [8:0] xcoord_t; // column 0..319
  typedef logic [7:0] ycoord_t; // row 0..239

  // up to 320*240 = 76800 masked pixels per frame
  typedef logic [16:0] pix_count_t;

  // worst case sum is 319 * 76800, just under 2^25
  typedef logic [24:0] coord_sum_t;

  // which plane gets thresholded
  // codes 3 and 7 are left unnamed and read as zero
  typedef enum logic [2:0] {
    sel_green = 3'd0,
    sel_red   = 3'd1,
    sel_blue  = 3'd2,
    sel_y     = 3'd4,
    sel_cr    = 3'd5,
    sel_cb    = 3'd6
  } channel_sel_t;

endpackage

//--- hw/color_convert.sv
`timescale 1ns/100ps
`include "tracker_defines.svh"

module color_convert import tracker_pkg::*; (
  input  logic      clk_pixel,
  input  logic      sys_rst,
  input  logic      in_valid,
  input  pixel565_t pixel,
  input  xcoord_t   hcount,
  input  ycoord_t   vcount,
  input  logic      frame_end,
  output logic      out_valid,
  output color8_t   red,
  output color8_t   green,
  output color8_t   blue,
  output color8_t   luma,
  output color8_t   cr,
  output color8_t   cb,
  output xcoord_t   out_hcount,
  output ycoord_t   out_vcount,
  output logic      out_frame_end
);

  localparam int DEPTH = `CONV_LATENCY;

  color8_t r_in, g_in, b_in; // 565 widened to 8 bits, low bits zero
  logic signed [17:0] y_r_p, y_g_p, y_b_p; // stage one products
  logic signed [17:0] cb_r_p, cb_g_p, cb_b_p;
  logic signed [17:0] cr_r_p, cr_g_p, cr_b_p;
  logic signed [17:0] y_sum, cb_sum, cr_sum; // stage two, rounding included
  color8_t red_d [DEPTH];
  color8_t green_d [DEPTH];
  color8_t blue_d [DEPTH];
  logic    valid_d [DEPTH];
  logic    frame_end_d [DEPTH];
  xcoord_t hcount_d [DEPTH];
  ycoord_t vcount_d [DEPTH];

  assign r_in = {pixel[15:11], 3'b000};
  assign g_in = {pixel[10:5], 2'b00};
  assign b_in = {pixel[4:0], 3'b000};

  // three registered stages: multiply, add, shift and offset
  always_ff @(posedge clk_pixel) begin
    y_r_p  <= `COEF_Y_R * $signed({10'd0, r_in}); // operands zero extended, kept signed
    y_g_p  <= `COEF_Y_G * $signed({10'd0, g_in});
    y_b_p  <= `COEF_Y_B * $signed({10'd0, b_in});
    cb_r_p <= `COEF_CB_R * $signed({10'd0, r_in});
    cb_g_p <= `COEF_CB_G * $signed({10'd0, g_in});
    cb_b_p <= `COEF_CB_B * $signed({10'd0, b_in});
    cr_r_p <= `COEF_CR_R * $signed({10'd0, r_in});
    cr_g_p <= `COEF_CR_G * $signed({10'd0, g_in});
    cr_b_p <= `COEF_CR_B * $signed({10'd0, b_in});

    y_sum  <= y_r_p + y_g_p + y_b_p + 18'sd128; // +128 rounds the >> 8
    cb_sum <= cb_r_p + cb_g_p + cb_b_p + 18'sd128;
    cr_sum <= cr_r_p + cr_g_p + cr_b_p + 18'sd128;

    luma <= color8_t'((y_sum >>> 8) + 18'sd16); // only the low byte survives
    cb   <= color8_t'((cb_sum >>> 8) + 18'sd128);
    cr   <= color8_t'((cr_sum >>> 8) + 18'sd128);
  end

  // rgb and coordinates ride along so all six planes leave together
  always_ff @(posedge clk_pixel) begin
    red_d[0]    <= r_in;
    green_d[0]  <= g_in;
    blue_d[0]   <= b_in;
    hcount_d[0] <= hcount;
    vcount_d[0] <= vcount;
    for (int i = 1; i < DEPTH; i++) begin
      red_d[i]    <= red_d[i-1];
      green_d[i]  <= green_d[i-1];
      blue_d[i]   <= blue_d[i-1];
      hcount_d[i] <= hcount_d[i-1];
      vcount_d[i] <= vcount_d[i-1];
    end
  end

  // strobes get cleared by reset
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        valid_d[i]     <= 1'b0;
        frame_end_d[i] <= 1'b0;
      end
    end else begin
      valid_d[0]     <= in_valid;
      frame_end_d[0] <= frame_end;
      for (int i = 1; i < DEPTH; i++) begin
        valid_d[i]     <= valid_d[i-1];
        frame_end_d[i] <= frame_end_d[i-1];
      end
    end
  end

  assign out_valid     = valid_d[DEPTH-1];
  assign out_frame_end = frame_end_d[DEPTH-1];
  assign red           = red_d[DEPTH-1];
  assign green         = green_d[DEPTH-1];
  assign blue          = blue_d[DEPTH-1];
  assign out_hcount    = hcount_d[DEPTH-1];
  assign out_vcount    = vcount_d[DEPTH-1];

  // the end-of-frame marker is its own beat, never riding on a pixel
  a_frame_end_alone: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    !(frame_end && in_valid));

endmodule

//--- hw/channel_threshold.sv
`timescale 1ns/100ps

module channel_threshold import tracker_pkg::*; (
  input  logic         clk_pixel,
  input  logic         sys_rst,
  input  logic         in_valid,
  input  color8_t      red,
  input  color8_t      green,
  input  color8_t      blue,
  input  color8_t      luma,
  input  color8_t      cr,
  input  color8_t      cb,
  input  xcoord_t      in_hcount,
  input  ycoord_t      in_vcount,
  input  logic         in_frame_end,
  input  channel_sel_t channel_sel, // static for a whole frame
  input  color8_t      lower_bound,
  input  color8_t      upper_bound,
  output logic         mask_valid,
  output logic         mask,
  output xcoord_t      mask_hcount,
  output ycoord_t      mask_vcount,
  output logic         mask_frame_end
);

  color8_t chan; // plane picked by channel_sel
  logic    in_range;

  always_comb begin
    case (channel_sel)
      sel_green: chan = green;
      sel_red:   chan = red;
      sel_blue:  chan = blue;
      sel_y:     chan = luma;
      sel_cr:    chan = cr;
      sel_cb:    chan = cb;
      default:   chan = '0; // codes 3 and 7
    endcase
  end

  // both bounds inclusive
  assign in_range = (chan >= lower_bound) && (chan <= upper_bound);

  // mask bit and coordinates, meaningful only with mask_valid
  always_ff @(posedge clk_pixel) begin
    mask        <= in_range;
    mask_hcount <= in_hcount;
    mask_vcount <= in_vcount;
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      mask_valid     <= 1'b0;
      mask_frame_end <= 1'b0;
    end else begin
      mask_valid     <= in_valid;
      mask_frame_end <= in_frame_end;
    end
  end

endmodule

//--- hw/serial_divider.sv
`timescale 1ns/100ps

// restoring divider, dividend shifts out msb first while quotient bits shift in
module serial_divider #(
  parameter int DIVIDEND_W = 25,
  parameter int DIVISOR_W  = 17,
  parameter int QUOTIENT_W = 9  // result assumed to fit, upper bits dropped
) (
  input  logic                  clk_pixel,
  input  logic                  sys_rst,
  input  logic                  start,
  input  logic [DIVIDEND_W-1:0] dividend,
  input  logic [DIVISOR_W-1:0]  divisor,    // never zero
  output logic                  busy,
  output logic                  done,       // one cycle, quotient valid here
  output logic [QUOTIENT_W-1:0] quotient
);

  localparam int STEPS = DIVIDEND_W; // one bit per cycle, first one on the start edge
  localparam int CNT_W = $clog2(STEPS);

  logic [CNT_W-1:0]      step_cnt;
  logic [DIVISOR_W-1:0]  rem_q, div_q;  // partial remainder and held divisor
  logic [DIVIDEND_W-1:0] shift_q;       // dividend in, quotient out
  logic [DIVISOR_W-1:0]  rem_src, div_src, rem_next;
  logic [DIVIDEND_W-1:0] shift_src, shift_next;
  logic [DIVISOR_W:0]    trial;
  logic                  q_bit;

  // on start the step works straight off the inputs
  always_comb begin
    rem_src    = start ? '0 : rem_q;
    div_src    = start ? divisor : div_q;
    shift_src  = start ? dividend : shift_q;
    trial      = {rem_src, shift_src[DIVIDEND_W-1]};
    q_bit      = (trial >= {1'b0, div_src});
    rem_next   = q_bit ? DIVISOR_W'(trial - {1'b0, div_src}) : trial[DIVISOR_W-1:0];
    shift_next = {shift_src[DIVIDEND_W-2:0], q_bit};
  end

  always_ff @(posedge clk_pixel) begin
    if (start || busy) begin
      rem_q   <= rem_next;
      shift_q <= shift_next;
    end
    if (start) div_q <= divisor;
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      step_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy     <= 1'b1;
        step_cnt <= CNT_W'(1);
      end else if (busy) begin
        step_cnt <= step_cnt + 1'b1;
        if (step_cnt == CNT_W'(STEPS - 1)) begin // last bit lands this edge
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  assign quotient = shift_q[QUOTIENT_W-1:0];

  a_no_restart: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    start |-> !busy);

  // fixed latency the stats block relies on
  a_done_latency: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    start |-> ##(STEPS) done);

endmodule

//--- hw/blob_stats.sv
`timescale 1ns/100ps
`include "tracker_defines.svh"

module blob_stats import tracker_pkg::*; (
  input  logic       clk_pixel,
  input  logic       sys_rst,
  input  logic       mask_valid,
  input  logic       mask,
  input  xcoord_t    mask_hcount,
  input  ycoord_t    mask_vcount,
  input  logic       mask_frame_end,
  input  logic       stats_ready,
  output logic       stats_valid,
  output logic       obj_found,
  output pix_count_t pix_count,
  output xcoord_t    com_x,
  output ycoord_t    com_y,
  output xcoord_t    box_xmin,
  output xcoord_t    box_xmax,
  output ycoord_t    box_ymin,
  output ycoord_t    box_ymax
);

  typedef enum logic [1:0] {
    st_idle,
    st_dividing,
    st_holding
  } stats_state_t;

  stats_state_t state;

  pix_count_t acc_count; // running totals for the frame in flight
  coord_sum_t acc_xsum, acc_ysum;
  xcoord_t    acc_xmin, acc_xmax;
  ycoord_t    acc_ymin, acc_ymax;
  logic       hit;        // masked pixel this cycle
  logic       frame_take; // frame end that gets a result
  logic       div_start;
  logic       x_busy, x_done, y_busy, y_done;
  xcoord_t    x_quot;
  ycoord_t    y_quot;

  assign hit         = mask_valid && mask;
  // frame ends in dividing or holding are dropped
  assign frame_take  = mask_frame_end && (state == st_idle) && !x_busy && !y_busy;
  assign div_start   = frame_take && (acc_count != '0); // empty frame skips divide
  assign stats_valid = (state == st_holding);

  // accumulators restart on every frame end, taken or not
  always_ff @(posedge clk_pixel) begin
    if (sys_rst || mask_frame_end) begin
      acc_count <= '0;
      acc_xsum  <= '0;
      acc_ysum  <= '0;
      acc_xmin  <= xcoord_t'(`FRAME_W - 1); // min starts high, max low
      acc_xmax  <= '0;
      acc_ymin  <= ycoord_t'(`FRAME_H - 1);
      acc_ymax  <= '0;
    end else if (hit) begin
      acc_count <= acc_count + 1'b1;
      acc_xsum  <= acc_xsum + coord_sum_t'(mask_hcount);
      acc_ysum  <= acc_ysum + coord_sum_t'(mask_vcount);
      if (mask_hcount < acc_xmin) acc_xmin <= mask_hcount;
      if (mask_hcount > acc_xmax) acc_xmax <= mask_hcount;
      if (mask_vcount < acc_ymin) acc_ymin <= mask_vcount;
      if (mask_vcount > acc_ymax) acc_ymax <= mask_vcount;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:     if (frame_take) state <= (acc_count == '0) ? st_holding : st_dividing;
        st_dividing: if (x_done && y_done) state <= st_holding;
        st_holding:  if (stats_ready) state <= st_idle; // handshake completes
        default:     state <= st_idle;
      endcase
    end
  end

  // result fields, frozen from frame_take until the consumer takes them
  always_ff @(posedge clk_pixel) begin
    if (frame_take) begin
      obj_found <= (acc_count != '0);
      pix_count <= acc_count;
      if (acc_count == '0) begin
        box_xmin <= '0; // nothing seen so everything reads zero
        box_xmax <= '0;
        box_ymin <= '0;
        box_ymax <= '0;
        com_x    <= '0;
        com_y    <= '0;
      end else begin
        box_xmin <= acc_xmin;
        box_xmax <= acc_xmax;
        box_ymin <= acc_ymin;
        box_ymax <= acc_ymax;
      end
    end
    if ((state == st_dividing) && x_done && y_done) begin
      com_x <= x_quot;
      com_y <= y_quot;
    end
  end

  // both dividers load the live sums on the clearing edge
  serial_divider #(
    .DIVIDEND_W($bits(coord_sum_t)),
    .DIVISOR_W ($bits(pix_count_t)),
    .QUOTIENT_W($bits(xcoord_t))
  ) u_div_x (
    .clk_pixel(clk_pixel),
    .sys_rst  (sys_rst),
    .start    (div_start),
    .dividend (acc_xsum),
    .divisor  (acc_count),
    .busy     (x_busy),
    .done     (x_done),
    .quotient (x_quot)
  );

  serial_divider #(
    .DIVIDEND_W($bits(coord_sum_t)),
    .DIVISOR_W ($bits(pix_count_t)),
    .QUOTIENT_W($bits(ycoord_t))
  ) u_div_y (
    .clk_pixel(clk_pixel),
    .sys_rst  (sys_rst),
    .start    (div_start),
    .dividend (acc_ysum),
    .divisor  (acc_count),
    .busy     (y_busy),
    .done     (y_done),
    .quotient (y_quot)
  );

  // a stalled result keeps both valid and every field
  a_hold_stable: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    stats_valid && !stats_ready |=> stats_valid &&
      $stable({obj_found, pix_count, com_x, com_y, box_xmin, box_xmax, box_ymin, box_ymax}));

endmodule

//--- hw/blob_tracker.sv
`timescale 1ns/100ps

module blob_tracker import tracker_pkg::*; (
  input  logic         clk_pixel,
  input  logic         sys_rst,
  input  logic         pixel_valid, // no back-pressure on the pixel stream
  input  pixel565_t    pixel,
  input  xcoord_t      hcount,
  input  ycoord_t      vcount,
  input  logic         frame_end,
  input  channel_sel_t channel_sel,
  input  color8_t      lower_bound,
  input  color8_t      upper_bound,
  input  logic         stats_ready,
  output logic         stats_valid,
  output logic         obj_found,
  output pix_count_t   pix_count,
  output xcoord_t      com_x,
  output ycoord_t      com_y,
  output xcoord_t      box_xmin,
  output xcoord_t      box_xmax,
  output ycoord_t      box_ymin,
  output ycoord_t      box_ymax
);

  logic    conv_valid, conv_frame_end; // color_convert to channel_threshold
  color8_t conv_red, conv_green, conv_blue;
  color8_t conv_luma, conv_cr, conv_cb;
  xcoord_t conv_hcount;
  ycoord_t conv_vcount;
  logic    mask_valid, mask, mask_frame_end; // channel_threshold to blob_stats
  xcoord_t mask_hcount;
  ycoord_t mask_vcount;

  color_convert u_color_convert (
    .clk_pixel(clk_pixel), .sys_rst(sys_rst),
    .in_valid(pixel_valid), .pixel(pixel), .hcount(hcount), .vcount(vcount),
    .frame_end(frame_end),
    .out_valid(conv_valid),
    .red(conv_red), .green(conv_green), .blue(conv_blue),
    .luma(conv_luma), .cr(conv_cr), .cb(conv_cb),
    .out_hcount(conv_hcount), .out_vcount(conv_vcount), .out_frame_end(conv_frame_end)
  );

  channel_threshold u_channel_threshold (
    .clk_pixel(clk_pixel), .sys_rst(sys_rst),
    .in_valid(conv_valid),
    .red(conv_red), .green(conv_green), .blue(conv_blue),
    .luma(conv_luma), .cr(conv_cr), .cb(conv_cb),
    .in_hcount(conv_hcount), .in_vcount(conv_vcount), .in_frame_end(conv_frame_end),
    .channel_sel(channel_sel), .lower_bound(lower_bound), .upper_bound(upper_bound),
    .mask_valid(mask_valid), .mask(mask),
    .mask_hcount(mask_hcount), .mask_vcount(mask_vcount), .mask_frame_end(mask_frame_end)
  );

  blob_stats u_blob_stats (
    .clk_pixel(clk_pixel), .sys_rst(sys_rst),
    .mask_valid(mask_valid), .mask(mask),
    .mask_hcount(mask_hcount), .mask_vcount(mask_vcount), .mask_frame_end(mask_frame_end),
    .stats_ready(stats_ready), .stats_valid(stats_valid),
    .obj_found(obj_found), .pix_count(pix_count), .com_x(com_x), .com_y(com_y),
    .box_xmin(box_xmin), .box_xmax(box_xmax), .box_ymin(box_ymin), .box_ymax(box_ymax)
  );

endmodule

//--- sim/tb_blob_tracker.sv
`timescale 1ns/100ps
`include "tracker_defines.svh"

module tb_blob_tracker import tracker_pkg::*; ();

  localparam int GAP         = 64; // idle cycles after each frame_end
  localparam int NUM_FRAMES  = 13;
  localparam int PIXELS      = `FRAME_W * `FRAME_H;
  localparam int CYCLE_LIMIT = NUM_FRAMES * (PIXELS + GAP) + 2000;
  localparam int RESULT_WAIT = 4 + 1 + 25 + 1 + 16; // worst frame_end to valid, plus margin

  // one per-frame result, as seen on the output port
  typedef struct packed {
    logic       found;
    pix_count_t count;
    xcoord_t    com_x;
    ycoord_t    com_y;
    xcoord_t    xmin;
    xcoord_t    xmax;
    ycoord_t    ymin;
    ycoord_t    ymax;
  } result_t;

  logic         clk_pixel;
  logic         sys_rst;
  logic         pixel_valid;
  pixel565_t    pixel;
  xcoord_t      hcount;
  ycoord_t      vcount;
  logic         frame_end;
  channel_sel_t channel_sel;
  color8_t      lower_bound;
  color8_t      upper_bound;
  logic         stats_ready;
  logic         stats_valid;
  logic         obj_found;
  pix_count_t   pix_count;
  xcoord_t      com_x;
  ycoord_t      com_y;
  xcoord_t      box_xmin;
  xcoord_t      box_xmax;
  ycoord_t      box_ymin;
  ycoord_t      box_ymax;

  result_t     exp_q[$]; // model results waiting for the handshake
  result_t     held;     // fields seen on the last stalled sample
  logic        stalled = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          accepted = 0;
  int          expected_total = 0;
  int          cycles = 0;
  int unsigned seed_init;

  blob_tracker DUT (.*);

  initial clk_pixel = 1'b0;
  always #20 clk_pixel = ~clk_pixel; // 40 ns pixel clock

  task automatic next_cycle();
    @(posedge clk_pixel);
    #2; // inputs move just after the edge
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, want);
    end
  endtask

  // plane value of one camera word, 565 zero-filled then converted
  function automatic int channel_value(pixel565_t p, int code);
    int r;
    int g;
    int b;
    r = int'(p[15:11]) * 8;
    g = int'(p[10:5]) * 4;
    b = int'(p[4:0]) * 8;
    case (code)
      0: return g;
      1: return r;
      2: return b;
      4: return (((66 * r + 129 * g + 25 * b + 128) >>> 8) + 16) & 255;
      5: return (((112 * r - 94 * g - 18 * b + 128) >>> 8) + 128) & 255; // cr
      6: return (((-38 * r - 74 * g + 112 * b + 128) >>> 8) + 128) & 255; // cb
      default: return 0; // codes 3 and 7 read zero
    endcase
  endfunction

  // frame totals to the result the DUT should hand over
  function automatic result_t summarize(int count, int xsum, int ysum,
                                        int xmin, int xmax, int ymin, int ymax);
    result_t res;
    res = '0; // empty frame reads all zero
    if (count > 0) begin
      res.found = 1'b1;
      res.count = pix_count_t'(count);
      res.com_x = xcoord_t'(xsum / count); // sums are never negative so this is floor
      res.com_y = ycoord_t'(ysum / count);
      res.xmin  = xcoord_t'(xmin);
      res.xmax  = xcoord_t'(xmax);
      res.ymin  = ycoord_t'(ymin);
      res.ymax  = ycoord_t'(ymax);
    end
    return res;
  endfunction

  function automatic result_t dut_result();
    result_t res;
    res.found = obj_found;
    res.count = pix_count;
    res.com_x = com_x;
    res.com_y = com_y;
    res.xmin  = box_xmin;
    res.xmax  = box_xmax;
    res.ymin  = box_ymin;
    res.ymax  = box_ymax;
    return res;
  endfunction

  task automatic compare_result(input string prefix, input result_t got, input result_t want);
    check_value({prefix, "obj_found"}, 32'(got.found), 32'(want.found));
    check_value({prefix, "pix_count"}, 32'(got.count), 32'(want.count));
    check_value({prefix, "com_x"}, 32'(got.com_x), 32'(want.com_x));
    check_value({prefix, "com_y"}, 32'(got.com_y), 32'(want.com_y));
    check_value({prefix, "box_xmin"}, 32'(got.xmin), 32'(want.xmin));
    check_value({prefix, "box_xmax"}, 32'(got.xmax), 32'(want.xmax));
    check_value({prefix, "box_ymin"}, 32'(got.ymin), 32'(want.ymin));
    check_value({prefix, "box_ymax"}, 32'(got.ymax), 32'(want.ymax));
  endtask

  // kind 0 is a dim random background with a full-scale rectangle, kind 1 all random
  task automatic send_frame(input int kind, input int code, input int lo, input int hi,
                            input int rx0, input int ry0, input int rx1, input int ry1,
                            input bit keep);
    pixel565_t p;
    int count;
    int xsum;
    int ysum;
    int xmin;
    int xmax;
    int ymin;
    int ymax;
    int value;
    count = 0;
    xsum  = 0;
    ysum  = 0;
    xmin  = `FRAME_W;
    xmax  = 0;
    ymin  = `FRAME_H;
    ymax  = 0;
    channel_sel = channel_sel_t'(code[2:0]); // held for the whole frame
    lower_bound = color8_t'(lo);
    upper_bound = color8_t'(hi);
    for (int y = 0; y < `FRAME_H; y++) begin
      for (int x = 0; x < `FRAME_W; x++) begin
        if (kind == 0 && x >= rx0 && x <= rx1 && y >= ry0 && y <= ry1) begin
          p = 16'hffff; // every plane near full scale
        end else if (kind == 0) begin
          p = pixel565_t'($urandom) & 16'h7bef; // top bit of each field cleared
        end else begin
          p = pixel565_t'($urandom);
        end
        pixel_valid = 1'b1;
        pixel       = p;
        hcount      = xcoord_t'(x);
        vcount      = ycoord_t'(y);
        value = channel_value(p, code);
        if (value >= lo && value <= hi) begin // inclusive window
          count++;
          xsum += x;
          ysum += y;
          if (x < xmin) xmin = x;
          if (x > xmax) xmax = x;
          if (y < ymin) ymin = y;
          if (y > ymax) ymax = y;
        end
        next_cycle();
      end
    end
    pixel_valid = 1'b0;
    frame_end   = 1'b1; // own beat, after the last pixel
    if (keep) begin
      exp_q.push_back(summarize(count, xsum, ysum, xmin, xmax, ymin, ymax));
      expected_total++;
    end
    next_cycle();
    frame_end = 1'b0;
    repeat (GAP - 1) next_cycle();
  endtask

  task automatic await_result(input int target);
    int waited;
    waited = 0;
    while (accepted < target && waited < RESULT_WAIT) begin
      next_cycle();
      waited++;
    end
    if (accepted < target) begin
      errors++;
      $display("no result handed over within %0d cycles, at %0t", RESULT_WAIT, $time);
    end
  endtask

  task automatic wait_for_valid();
    int waited;
    waited = 0;
    while (!stats_valid && waited < RESULT_WAIT) begin
      next_cycle();
      waited++;
    end
    if (!stats_valid) begin
      errors++;
      $display("stats_valid never rose after the frame end, at %0t", $time);
    end
  endtask

  // handshake sampled mid-cycle, where valid, ready and fields are all settled
  always @(negedge clk_pixel) begin
    result_t live;
    result_t want;
    live = dut_result();
    if (!sys_rst) begin
      if (stalled) begin // last sample was valid without ready
        check_value("stats_valid", 32'(stats_valid), 32'd1);
        compare_result("held ", live, held);
      end
      if (stats_valid && stats_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("result handed over at %0t with no frame pending", $time);
        end else begin
          want = exp_q.pop_front();
          compare_result("", live, want);
        end
        accepted++;
      end
      stalled = stats_valid && !stats_ready;
      held    = live;
    end
  end

  always @(posedge clk_pixel) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the test sequence never finished", cycles);
      $display("checks %0d errors %0d results %0d", checks, errors, accepted);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    int lo;
    int hi;
    seed_init   = $urandom(32'h2dd32933); // single seed for the run
    sys_rst     = 1'b1;
    pixel_valid = 1'b0;
    pixel       = '0;
    hcount      = '0;
    vcount      = '0;
    frame_end   = 1'b0;
    channel_sel = sel_green;
    lower_bound = '0;
    upper_bound = '0;
    stats_ready = 1'b1;
    repeat (16) @(posedge clk_pixel);
    #2;
    sys_rst = 1'b0;
    next_cycle();

    // red, green, blue against a bright rectangle
    send_frame(0, 1, 200, 255, 40, 30, 119, 89, 1'b1);
    await_result(expected_total);
    send_frame(0, 0, 200, 255, 200, 150, 311, 233, 1'b1);
    await_result(expected_total);
    send_frame(0, 2, 200, 255, 0, 0, 15, 9, 1'b1);
    await_result(expected_total);

    for (int code = 4; code <= 6; code++) begin // luma, cr, cb
      lo = int'($urandom_range(180));
      hi = lo + int'($urandom_range(75, 10));
      send_frame(1, code, lo, hi, 0, 0, 0, 0, 1'b1);
      await_result(expected_total);
    end

    send_frame(1, 4, 200, 100, 0, 0, 0, 0, 1'b1); // lower above upper, nothing passes
    await_result(expected_total);

    // unnamed codes read zero, so only lower_bound 0 lets pixels through
    send_frame(1, 3, 0, 255, 0, 0, 0, 0, 1'b1);
    await_result(expected_total);
    send_frame(1, 7, 0, 40, 0, 0, 0, 0, 1'b1);
    await_result(expected_total);
    send_frame(1, 3, 1, 255, 0, 0, 0, 0, 1'b1);
    await_result(expected_total);

    // consumer stalls across the next frame end
    stats_ready = 1'b0;
    send_frame(1, 1, 100, 200, 0, 0, 0, 0, 1'b1);
    wait_for_valid();
    send_frame(1, 4, 0, 255, 0, 0, 0, 0, 1'b0); // this one gets dropped
    stats_ready = 1'b1;
    await_result(expected_total);
    send_frame(1, 5, 90, 170, 0, 0, 0, 0, 1'b1);
    await_result(expected_total);

    repeat (GAP) next_cycle(); // room for a stray result to show up
    check_value("pending results", exp_q.size(), 0);
    check_value("accepted results", accepted, expected_total);
    $display("checks %0d errors %0d results %0d", checks, errors, accepted);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+include
hw/tracker_pkg.sv
hw/color_convert.sv
hw/channel_threshold.sv
hw/serial_divider.sv
hw/blob_stats.sv
hw/blob_tracker.sv
sim/tb_blob_tracker.sv

//--- run_sim.sh
#!/bin/bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f all.f --top-module tb_blob_tracker -o tb_blob_tracker
./obj_dir/tb_blob_tracker | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
  echo "simulation reported failure"
  exit 1
fi
